/* common/branch_pkg.sv */
package branch_pkg;

    // Data and address width
    localparam int xlen = 32;
    localparam int ilen = 32;  // Base ISA only, no compressed words

    // Major opcodes handled by the unit
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;

    // Conditional branch compare kinds
    localparam logic [2:0] f3_beq  = 3'd0;
    localparam logic [2:0] f3_bne  = 3'd1;
    localparam logic [2:0] f3_blt  = 3'd4;
    localparam logic [2:0] f3_bge  = 3'd5;
    localparam logic [2:0] f3_bltu = 3'd6;
    localparam logic [2:0] f3_bgeu = 3'd7;

    typedef enum logic [1:0] {
        cond  = 2'd0,
        jal   = 2'd1,
        jalr  = 2'd2,
        auipc = 2'd3
    } br_op_e;

    // Record leaving decode
    typedef struct packed {
        br_op_e            op;
        logic [2:0]        funct3;
        logic [4:0]        rd;
        logic [xlen-1:0]   imm;          // Already sign-extended
        logic [xlen-1:0]   pc;
        logic [xlen-1:0]   rs1_val;
        logic [xlen-1:0]   rs2_val;
        logic              pred_taken;
        logic [xlen-1:0]   pred_target;
    } dec_op_t;

    // Record leaving execute
    typedef struct packed {
        br_op_e            op;
        logic [4:0]        rd;
        logic              taken;
        logic [xlen-1:0]   target;
        logic [xlen-1:0]   link_val;     // pc + 4, or pc + imm for auipc
        logic              link;         // Register write wanted
        logic [xlen-1:0]   pc;
        logic              pred_taken;
        logic [xlen-1:0]   pred_target;
    } exe_res_t;

    // Issue side input
    typedef struct packed {
        logic [ilen-1:0]   instr;
        logic [xlen-1:0]   pc;
        logic [xlen-1:0]   rs1_val;
        logic [xlen-1:0]   rs2_val;
        logic              pred_taken;
        logic [xlen-1:0]   pred_target;
    } issue_t;

endpackage

/* branch/branch_decode.sv */
`timescale 1ns/1ps

module branch_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 valid_in,
    input  branch_pkg::issue_t   issue,
    input  logic                 squash,
    output logic                 dec_valid,
    output branch_pkg::dec_op_t  dec_op,
    output logic                 bad_op
);

    logic [branch_pkg::ilen-1:0] instr;
    logic [6:0]                  opcode;
    logic [2:0]                  funct3;
    logic [4:0]                  rd;

    logic [branch_pkg::xlen-1:0] imm_i;
    logic [branch_pkg::xlen-1:0] imm_b;
    logic [branch_pkg::xlen-1:0] imm_j;
    logic [branch_pkg::xlen-1:0] imm_u;

    logic [branch_pkg::xlen-1:0] imm;
    branch_pkg::br_op_e          op;
    logic                        known;
    branch_pkg::dec_op_t         dec_next;

    assign instr  = issue.instr;
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];

    // Immediate formats, sign bit is always instr[31]
    assign imm_i = {{(branch_pkg::xlen-12){instr[31]}}, instr[31:20]};
    assign imm_b = {{(branch_pkg::xlen-13){instr[31]}}, instr[31], instr[7],
                    instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{(branch_pkg::xlen-21){instr[31]}}, instr[31], instr[19:12],
                    instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};  // RV32 so no extension needed

    always_comb begin
        op    = branch_pkg::cond;
        imm   = imm_b;
        known = 1'b0;
        case (opcode)
            branch_pkg::opc_branch: begin
                op    = branch_pkg::cond;
                imm   = imm_b;
                known = (funct3[2:1] != 2'b01);  // funct3 2 and 3 are reserved
            end
            branch_pkg::opc_jal: begin
                op    = branch_pkg::jal;
                imm   = imm_j;
                known = 1'b1;
            end
            branch_pkg::opc_jalr: begin
                op    = branch_pkg::jalr;
                imm   = imm_i;
                known = 1'b1;
            end
            branch_pkg::opc_auipc: begin
                op    = branch_pkg::auipc;
                imm   = imm_u;
                known = 1'b1;
            end
            default: begin
                known = 1'b0;  // Not ours, reported and dropped
            end
        endcase
    end

    always_comb begin
        dec_next.op          = op;
        dec_next.funct3      = funct3;
        dec_next.rd          = rd;
        dec_next.imm         = imm;
        dec_next.pc          = issue.pc;
        dec_next.rs1_val     = issue.rs1_val;
        dec_next.rs2_val     = issue.rs2_val;
        dec_next.pred_taken  = issue.pred_taken;
        dec_next.pred_target = issue.pred_target;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            bad_op    <= 1'b0;
        end else begin
            // A redirect kills whatever arrives in the same cycle
            dec_valid <= valid_in && known && !squash;
            bad_op    <= valid_in && !known && !squash;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_in) begin
            dec_op <= dec_next;
        end
    end

    // Squash from resolve lasts one cycle only
    a_squash_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        squash |=> !squash
    );

endmodule

/* branch/branch_execute.sv */
`timescale 1ns/1ps

module branch_execute (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 dec_valid,
    input  branch_pkg::dec_op_t  dec_op,
    input  logic                 squash,
    output logic                 exe_valid,
    output branch_pkg::exe_res_t exe_res
);

    logic                        eq;
    logic                        lt;
    logic                        ltu;
    logic                        cond_true;
    logic                        taken;

    logic [branch_pkg::xlen-1:0] base;
    logic [branch_pkg::xlen-1:0] sum;
    logic [branch_pkg::xlen-1:0] target;
    logic [branch_pkg::xlen-1:0] pc_plus4;
    logic [branch_pkg::xlen-1:0] link_val;
    logic                        link;
    branch_pkg::exe_res_t        res_next;

    // Comparators on the operands of this cycle
    assign eq  = (dec_op.rs1_val == dec_op.rs2_val);
    assign lt  = ($signed(dec_op.rs1_val) < $signed(dec_op.rs2_val));
    assign ltu = (dec_op.rs1_val < dec_op.rs2_val);

    always_comb begin
        case (dec_op.funct3)
            branch_pkg::f3_beq:  cond_true = eq;
            branch_pkg::f3_bne:  cond_true = !eq;
            branch_pkg::f3_blt:  cond_true = lt;
            branch_pkg::f3_bge:  cond_true = !lt;
            branch_pkg::f3_bltu: cond_true = ltu;
            branch_pkg::f3_bgeu: cond_true = !ltu;
            default:             cond_true = 1'b0;  // Rejected in decode
        endcase
    end

    // Only jalr adds to rs1, the rest are pc relative
    assign base     = (dec_op.op == branch_pkg::jalr) ? dec_op.rs1_val : dec_op.pc;
    assign sum      = base + dec_op.imm;
    assign target   = (dec_op.op == branch_pkg::jalr) ? {sum[branch_pkg::xlen-1:1], 1'b0} : sum;
    assign pc_plus4 = dec_op.pc + branch_pkg::xlen'(4);

    always_comb begin
        case (dec_op.op)
            branch_pkg::cond:  taken = cond_true;
            branch_pkg::jal:   taken = 1'b1;
            branch_pkg::jalr:  taken = 1'b1;
            default:           taken = 1'b0;  // auipc
        endcase
    end

    // For auipc the adder output is the value written back
    assign link_val = (dec_op.op == branch_pkg::auipc) ? sum : pc_plus4;
    assign link     = (dec_op.op != branch_pkg::cond) && (dec_op.rd != 5'd0);

    always_comb begin
        res_next.op          = dec_op.op;
        res_next.rd          = dec_op.rd;
        res_next.taken       = taken;
        res_next.target      = target;
        res_next.link_val    = link_val;
        res_next.link        = link;
        res_next.pc          = dec_op.pc;
        res_next.pred_taken  = dec_op.pred_taken;
        res_next.pred_target = dec_op.pred_target;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= dec_valid && !squash;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            exe_res <= res_next;
        end
    end

    // Reserved compare kinds must never get past decode
    a_cond_funct3_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        dec_valid && (dec_op.op == branch_pkg::cond) |-> (dec_op.funct3[2:1] != 2'b01)
    );

endmodule

/* branch/branch_resolve.sv */
`timescale 1ns/1ps

module branch_resolve (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        exe_valid,
    input  branch_pkg::exe_res_t        exe_res,
    output logic                        done,
    output logic                        wb_en,
    output logic [4:0]                  wb_rd,
    output logic [branch_pkg::xlen-1:0] wb_data,
    output logic                        redirect,
    output logic [branch_pkg::xlen-1:0] redirect_pc,
    output logic                        squash
);

    logic                        live;
    logic                        dir_wrong;
    logic                        tgt_wrong;
    logic                        mispredict;
    logic [branch_pkg::xlen-1:0] next_pc;

    // Result sitting in execute while we redirect is younger, drop it
    assign live = exe_valid && !redirect;

    assign dir_wrong  = (exe_res.taken != exe_res.pred_taken);
    assign tgt_wrong  = exe_res.taken && exe_res.pred_taken &&
                        (exe_res.target != exe_res.pred_target);
    assign mispredict = (exe_res.op != branch_pkg::auipc) && (dir_wrong || tgt_wrong);

    assign next_pc = exe_res.taken ? exe_res.target
                                   : exe_res.pc + branch_pkg::xlen'(4);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done     <= 1'b0;
            wb_en    <= 1'b0;
            redirect <= 1'b0;
        end else begin
            done     <= live;
            wb_en    <= live && exe_res.link;
            redirect <= live && mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (live) begin
            wb_rd       <= exe_res.rd;
            wb_data     <= exe_res.link_val;
            redirect_pc <= next_pc;
        end
    end

    assign squash = redirect;  // Clears decode and execute this cycle

    a_redirect_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect |-> done
    );

    a_wb_rd_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_en |-> (wb_rd != 5'd0)
    );

endmodule

/* src/branch_unit_top.sv */
`timescale 1ns/1ps

module branch_unit_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        valid_in,
    input  branch_pkg::issue_t          issue,
    output logic                        done,
    output logic                        wb_en,
    output logic [4:0]                  wb_rd,
    output logic [branch_pkg::xlen-1:0] wb_data,
    output logic                        redirect,
    output logic [branch_pkg::xlen-1:0] redirect_pc,
    output logic                        bad_op
);

    logic                 dec_valid;
    branch_pkg::dec_op_t  dec_op;
    logic                 exe_valid;
    branch_pkg::exe_res_t exe_res;
    logic                 squash;     // From resolve back to both earlier stages

    branch_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .issue     (issue),
        .squash    (squash),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .bad_op    (bad_op)
    );

    branch_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .squash    (squash),
        .exe_valid (exe_valid),
        .exe_res   (exe_res)
    );

    // Writeback and misprediction check
    branch_resolve u_resolve (
        .clk         (clk),
        .rst_n       (rst_n),
        .exe_valid   (exe_valid),
        .exe_res     (exe_res),
        .done        (done),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .squash      (squash)
    );

endmodule

/* sim/branch_unit_tb.sv */
`timescale 1ns/1ps

module branch_unit_tb;

    localparam int test_cycles = 107;                   // Sum of all steps below, reset included
    localparam int max_cycles  = 3 * test_cycles + 70;

    // What the outputs should show when an operation reaches resolve
    typedef struct packed {
        logic        done;
        logic        bad;
        logic        wb_en;
        logic [4:0]  rd;
        logic [31:0] wb_data;
        logic        redirect;
        logic [31:0] redirect_pc;
    } expect_t;

    logic               clk;
    logic               rst_n;
    logic               valid_in;
    branch_pkg::issue_t issue;
    logic               done;
    logic               wb_en;
    logic [4:0]         wb_rd;
    logic [31:0]        wb_data;
    logic               redirect;
    logic [31:0]        redirect_pc;
    logic               bad_op;

    expect_t pipe [0:3];  // Index is cycles since issue
    integer  seed;
    int      cycles;

    branch_unit_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_in    (valid_in),
        .issue       (issue),
        .done        (done),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .bad_op      (bad_op)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > max_cycles) begin
            $display("Timeout: tests still running after %0d cycles", max_cycles);
            $display("*** TEST FAILED ***");
            $fatal(1, "Timeout");
        end
    end

    function automatic logic [31:0] encode(input branch_pkg::br_op_e kind, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [31:0] imm);
        case (kind)
            branch_pkg::cond: return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11],
                                      branch_pkg::opc_branch};
            branch_pkg::jal:  return {imm[20], imm[10:1], imm[11], imm[19:12], rd,
                                      branch_pkg::opc_jal};
            branch_pkg::jalr: return {imm[11:0], 5'd1, 3'b000, rd, branch_pkg::opc_jalr};
            default:          return {imm[31:12], rd, branch_pkg::opc_auipc};
        endcase
    endfunction

    function automatic logic ref_taken(input branch_pkg::br_op_e kind, input logic [2:0] f3,
                                       input logic [31:0] rs1, input logic [31:0] rs2);
        if (kind == branch_pkg::jal || kind == branch_pkg::jalr)
            return 1'b1;
        if (kind == branch_pkg::auipc)
            return 1'b0;
        case (f3)
            3'd0:    return rs1 == rs2;
            3'd1:    return rs1 != rs2;
            3'd4:    return $signed(rs1) < $signed(rs2);
            3'd5:    return $signed(rs1) >= $signed(rs2);
            3'd6:    return rs1 < rs2;
            default: return rs1 >= rs2;
        endcase
    endfunction

    function automatic logic [31:0] ref_target(input branch_pkg::br_op_e kind,
                                               input logic [31:0] imm, input logic [31:0] pc,
                                               input logic [31:0] rs1);
        if (kind == branch_pkg::jalr)
            return (rs1 + imm) & 32'hffff_fffe;  // Bit 0 dropped
        return pc + imm;
    endfunction

    function automatic expect_t expect_op(input branch_pkg::br_op_e kind, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [31:0] imm,
                                          input logic [31:0] pc, input logic [31:0] rs1,
                                          input logic [31:0] rs2, input logic pt,
                                          input logic [31:0] ptgt);
        expect_t     e;
        logic        taken;
        logic [31:0] target;
        taken  = ref_taken(kind, f3, rs1, rs2);
        target = ref_target(kind, imm, pc, rs1);
        e             = '0;
        e.done        = 1'b1;
        e.wb_en       = (kind != branch_pkg::cond) && (rd != 5'd0);
        e.rd          = rd;
        e.wb_data     = (kind == branch_pkg::auipc) ? pc + imm : pc + 32'd4;
        e.redirect    = (kind != branch_pkg::auipc) &&
                        ((taken != pt) || (taken && pt && target != ptgt));
        e.redirect_pc = taken ? target : pc + 32'd4;
        return e;
    endfunction

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // One clock: check what is due now, then drive the next issue slot
    task automatic step(input logic valid, input logic [31:0] instr, input logic [31:0] pc,
                        input logic [31:0] rs1, input logic [31:0] rs2, input logic pt,
                        input logic [31:0] ptgt, input expect_t e);
        expect_t next;
        @(posedge clk);
        #1;
        pipe[3] = pipe[2];
        pipe[2] = pipe[1];
        pipe[1] = pipe[0];
        check_val("done", {31'b0, done}, {31'b0, pipe[3].done});
        check_val("wb_en", {31'b0, wb_en}, {31'b0, pipe[3].wb_en});
        check_val("redirect", {31'b0, redirect}, {31'b0, pipe[3].redirect});
        check_val("bad_op", {31'b0, bad_op}, {31'b0, pipe[1].bad});  // One cycle after issue
        if (pipe[3].wb_en) begin
            check_val("wb_rd", {27'b0, wb_rd}, {27'b0, pipe[3].rd});
            check_val("wb_data", wb_data, pipe[3].wb_data);
        end
        if (pipe[3].redirect)
            check_val("redirect_pc", redirect_pc, pipe[3].redirect_pc);
        next = valid ? e : '0;
        // Redirect kills everything younger, including this cycle's issue
        if (pipe[3].redirect) begin
            pipe[2] = '0;
            pipe[1] = '0;
            next    = '0;
        end
        pipe[0]           = next;
        valid_in          = valid;
        issue.instr       = instr;
        issue.pc          = pc;
        issue.rs1_val     = rs1;
        issue.rs2_val     = rs2;
        issue.pred_taken  = pt;
        issue.pred_target = ptgt;
    endtask

    task automatic idle(input int n);
        repeat (n) step(1'b0, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0, 32'h0, '0);
    endtask

    task automatic issue_op(input branch_pkg::br_op_e kind, input logic [2:0] f3,
                            input logic [4:0] rd, input logic [31:0] imm, input logic [31:0] pc,
                            input logic [31:0] rs1, input logic [31:0] rs2, input logic pt,
                            input logic [31:0] ptgt);
        step(1'b1, encode(kind, f3, rd, imm), pc, rs1, rs2, pt, ptgt,
             expect_op(kind, f3, rd, imm, pc, rs1, rs2, pt, ptgt));
    endtask

    // Same as issue_op with the front end guessing right
    task automatic issue_good(input branch_pkg::br_op_e kind, input logic [2:0] f3,
                              input logic [4:0] rd, input logic [31:0] imm,
                              input logic [31:0] pc, input logic [31:0] rs1,
                              input logic [31:0] rs2);
        logic taken;
        taken = ref_taken(kind, f3, rs1, rs2);
        issue_op(kind, f3, rd, imm, pc, rs1, rs2, taken,
                 taken ? ref_target(kind, imm, pc, rs1) : 32'h0);
    endtask

    task automatic issue_bad(input logic [31:0] instr);
        expect_t e;
        e     = '0;
        e.bad = 1'b1;
        step(1'b1, instr, 32'h0000_5000, 32'h1, 32'h2, 1'b0, 32'h0, e);
    endtask

    task automatic test_compares();
        logic [2:0]  f3_list [0:5];
        logic [31:0] a [0:4];
        logic [31:0] b [0:4];
        int          i;
        int          j;
        f3_list = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        a[0] = 32'd5;
        b[0] = 32'd5;
        a[1] = 32'hffff_fffd;  // -3 against 4
        b[1] = 32'd4;
        a[2] = 32'h8000_0000;  // Huge unsigned, most negative signed
        b[2] = 32'd1;
        a[3] = $random(seed);
        b[3] = $random(seed);
        a[4] = $random(seed);
        b[4] = $random(seed);
        for (i = 0; i < 6; i++) begin
            for (j = 0; j < 5; j++) begin
                issue_good(branch_pkg::cond, f3_list[i], 5'd0,
                           (j % 2 == 1) ? 32'hffff_fff8 : 32'h0000_0124,
                           32'h1000 + 32'(i * 64 + j * 4), a[j], b[j]);
            end
        end
        idle(4);
    endtask

    task automatic test_jumps();
        issue_good(branch_pkg::jal, 3'd0, 5'd1, 32'h0000_0800, 32'h2000, 32'h0, 32'h0);
        issue_good(branch_pkg::jal, 3'd0, 5'd0, 32'hffff_fff0, 32'h2100, 32'h0, 32'h0);
        issue_good(branch_pkg::jal, 3'd0, 5'd31, 32'h000f_f000, 32'h2200, 32'h0, 32'h0);
        issue_good(branch_pkg::jalr, 3'd0, 5'd5, 32'h10, 32'h2300, 32'h1001, 32'h0);  // Odd sum
        issue_good(branch_pkg::jalr, 3'd0, 5'd0, 32'hffff_fffc, 32'h2400, 32'h2000, 32'h0);
        issue_good(branch_pkg::jalr, 3'd0, 5'd6, 32'h7ff, 32'h2500, 32'h3000, 32'h0);
        // Predicted not taken so the cleared target shows on redirect_pc
        issue_op(branch_pkg::jalr, 3'd0, 5'd8, 32'h0ff, 32'h2600, 32'h4000, 32'h0, 1'b0, 32'h0);
        idle(4);
    endtask

    task automatic test_auipc();
        issue_good(branch_pkg::auipc, 3'd0, 5'd7, 32'h1234_5000, 32'h4000, 32'h0, 32'h0);
        issue_good(branch_pkg::auipc, 3'd0, 5'd9, 32'hffff_f000, 32'h4004, 32'h0, 32'h0);
        issue_good(branch_pkg::auipc, 3'd0, 5'd0, 32'h0000_1000, 32'h4008, 32'h0, 32'h0);
        issue_op(branch_pkg::auipc, 3'd0, 5'd10, 32'h8000_0000, 32'h4010, 32'h0, 32'h0,
                 1'b1, 32'h5555);  // Prediction must be ignored
        idle(4);
    endtask

    task automatic test_mispredict();
        // Taken branch guessed not taken, then the squash window and a clean op
        issue_op(branch_pkg::cond, 3'd0, 5'd0, 32'h40, 32'h6000, 32'd9, 32'd9, 1'b0, 32'h0);
        issue_good(branch_pkg::jal, 3'd0, 5'd2, 32'h8, 32'h6004, 32'h0, 32'h0);
        issue_good(branch_pkg::jal, 3'd0, 5'd3, 32'h8, 32'h6008, 32'h0, 32'h0);
        issue_good(branch_pkg::jal, 3'd0, 5'd4, 32'h8, 32'h600c, 32'h0, 32'h0);  // Meets redirect
        issue_good(branch_pkg::jal, 3'd0, 5'd5, 32'h8, 32'h6040, 32'h0, 32'h0);
        idle(4);
        // Right direction, wrong target
        issue_op(branch_pkg::jalr, 3'd0, 5'd1, 32'h20, 32'h7000, 32'h8000, 32'h0, 1'b1, 32'h8000);
        issue_good(branch_pkg::auipc, 3'd0, 5'd11, 32'h0000_1000, 32'h7004, 32'h0, 32'h0);
        issue_good(branch_pkg::auipc, 3'd0, 5'd12, 32'h0000_2000, 32'h7008, 32'h0, 32'h0);
        idle(1);
        issue_good(branch_pkg::auipc, 3'd0, 5'd13, 32'h0000_3000, 32'h8020, 32'h0, 32'h0);
        idle(4);
        // Not taken branch guessed taken
        issue_op(branch_pkg::cond, 3'd1, 5'd0, 32'h40, 32'h9000, 32'd3, 32'd3, 1'b1, 32'h9040);
        issue_good(branch_pkg::jal, 3'd0, 5'd14, 32'h10, 32'h9040, 32'h0, 32'h0);
        issue_good(branch_pkg::jal, 3'd0, 5'd15, 32'h10, 32'h9044, 32'h0, 32'h0);
        idle(1);
        issue_good(branch_pkg::jal, 3'd0, 5'd16, 32'h10, 32'h9004, 32'h0, 32'h0);
        idle(4);
    endtask

    task automatic test_pipeline();
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        int          i;
        for (i = 0; i < 12; i++) begin
            pc       = $random(seed);
            pc[1:0]  = 2'b00;
            rs1      = $random(seed);
            rs2      = $random(seed);
            case (i % 3)
                0:       issue_good(branch_pkg::cond, 3'(4 + (i % 4)), 5'd0, 32'h100, pc, rs1, rs2);
                1:       issue_good(branch_pkg::jal, 3'd0, 5'(i + 1), 32'h400, pc, 32'h0, 32'h0);
                default: issue_good(branch_pkg::auipc, 3'd0, 5'(i + 1), 32'h0abc_d000, pc,
                                    32'h0, 32'h0);
            endcase
        end
        idle(4);
    endtask

    task automatic test_reject();
        issue_bad(32'h0020_81b3);  // add x3, x1, x2
        issue_bad(encode(branch_pkg::cond, 3'd2, 5'd0, 32'h10));
        issue_bad(encode(branch_pkg::cond, 3'd3, 5'd0, 32'h10));
        issue_good(branch_pkg::jal, 3'd0, 5'd20, 32'h20, 32'ha000, 32'h0, 32'h0);
        idle(4);
    endtask

    initial begin
        int k;
        seed          = 32'h388a987a;
        clk           = 1'b0;
        rst_n         = 1'b0;
        valid_in      = 1'b0;
        issue         = '0;
        cycles        = 0;
        for (k = 0; k < 4; k++)
            pipe[k] = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_compares();
        test_jumps();
        test_auipc();
        test_mispredict();
        test_pipeline();
        test_reject();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* tb.f */
common/branch_pkg.sv
branch/branch_decode.sv
branch/branch_execute.sv
branch/branch_resolve.sv
src/branch_unit_top.sv
sim/branch_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= branch_unit_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

# Build the simulation executable from the file list
compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the executable is the test result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
